/* hdl/pe_defs.svh */
`ifndef PE_DEFS_SVH
`define PE_DEFS_SVH

// Number of PE columns in the row.
`define PE_COLS 4

// Activation byte width.
`define A_W 8

// Weight word width and weight memory depth per PE.
`define B_W 8
`define B_D 4

// Accumulator and result chain width.
`define RES_W 32

// Width of the per-PE config word.
`define CFG_W 4

`endif

/* hdl/pe_pkg.sv */
package pe_pkg;

	// Product precision of one PE.
	typedef enum logic [1:0] {
		P8X8   = 2'd0,
		P8X16  = 2'd1,
		P16X16 = 2'd2
	} prec_mode_t;

	// Config word, shifted in MSB first over the config chain.
	typedef struct packed {
		prec_mode_t mode;
		logic       a_signed;
		logic       b_signed;
	} pe_cfg_t;

	// Partial-product cycles needed by each mode.
	function automatic logic [2:0] pp_cycles(prec_mode_t mode);
		case (mode)
			P8X16:   return 3'd2;
			P16X16:  return 3'd4;
			default: return 3'd1;
		endcase
	endfunction

endpackage

/* hdl/pe_ctrl_if.sv */
`timescale 1ns/100ps
`include "pe_defs.svh"

// Per-cycle datapath controls of one PE.
interface pe_ctrl_if;
	logic                       a_sel;  // 1 picks the older byte, the low half of a 16-bit value.
	logic                       a_s;    // Activation byte is signed.
	logic [$clog2(`B_D)-1:0]    b_addr; // Weight word for this partial product.
	logic                       b_s;    // Weight word is signed.
	logic [1:0]                 shift;  // 0, 1 or 2 selects a shift of 0, 8 or 16 bits.
	logic                       acc_en; // Add the shifted product this cycle.

	modport ctrl (
		output a_sel,
		output a_s,
		output b_addr,
		output b_s,
		output shift,
		output acc_en
	);

	modport dp (
		input a_sel,
		input a_s,
		input b_addr,
		input b_s,
		input shift,
		input acc_en
	);
endinterface

/* hdl/stream_flex.sv */
`timescale 1ns/100ps
`include "pe_defs.svh"

module stream_flex (
	input  logic            clk,
	input  logic            rst,
	input  logic [`A_W-1:0] a_in,
	input  logic            a_en,
	pe_ctrl_if.dp           ctrl,
	output logic [`A_W-1:0] a_fwd,
	output logic [`A_W-1:0] a_mul
);

	logic [`A_W-1:0] byte_new;
	logic [`A_W-1:0] byte_old;

	// Two-byte shift buffer. A 16-bit activation arrives low byte first,
	// so after both writes the low byte sits in the older slot.
	always_ff @(posedge clk) begin
		if (rst) begin
			byte_new <= '0;
			byte_old <= '0;
		end else if (a_en) begin
			byte_old <= byte_new;
			byte_new <= a_in;
		end
	end

	assign a_fwd = byte_new; // Newest byte moves on to the next column.

	// In the 8-bit modes the only byte written is the newest one.
	assign a_mul = ctrl.a_sel ? byte_old : byte_new;

endmodule

/* hdl/stream_mem.sv */
`timescale 1ns/100ps
`include "pe_defs.svh"

module stream_mem (
	input  logic            clk,
	input  logic            rst,
	input  logic [`B_W-1:0] b_in,
	input  logic            b_en,
	pe_ctrl_if.dp           ctrl,
	output logic [`B_W-1:0] b_mul,
	output logic [`B_W-1:0] b_cascade
);

	logic [`B_W-1:0] mem [0:`B_D-1];

	// Weights shift in at address 0 and leave from the top address.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `B_D; i++) begin
				mem[i] <= '0;
			end
		end else if (b_en) begin
			mem[0] <= b_in;
			for (int i = 1; i < `B_D; i++) begin
				mem[i] <= mem[i-1];
			end
		end
	end

	// The oldest word feeds the next column's memory.
	assign b_cascade = mem[`B_D-1];

	assign b_mul = mem[ctrl.b_addr]; // Read port for the multiplier.

endmodule

/* hdl/mult_shift.sv */
`timescale 1ns/100ps
`include "pe_defs.svh"

module mult_shift (
	input  logic [`A_W-1:0]   a,
	input  logic [`B_W-1:0]   b,
	pe_ctrl_if.dp             ctrl,
	output logic [`RES_W-1:0] prod
);

	localparam int P_W = `A_W + `B_W + 2;

	logic signed [`A_W:0]     a_x;
	logic signed [`B_W:0]     b_x;
	logic signed [P_W-1:0]    p;
	logic        [`RES_W-1:0] p_ext;

	// One extra bit per operand holds the sign, or zero when unsigned.
	assign a_x = {ctrl.a_s & a[`A_W-1], a};
	assign b_x = {ctrl.b_s & b[`B_W-1], b};

	assign p = a_x * b_x;

	assign p_ext = {{(`RES_W-P_W){p[P_W-1]}}, p}; // Sign extended to the full result width.

	// Weighting of the partial product inside the wide product.
	always_comb begin
		case (ctrl.shift)
			2'd1:    prod = p_ext << 8;
			2'd2:    prod = p_ext << 16;
			default: prod = p_ext;
		endcase
	end

endmodule

/* hdl/accumulator.sv */
`timescale 1ns/100ps
`include "pe_defs.svh"

module accumulator (
	input  logic              clk,
	input  logic              rst,
	pe_ctrl_if.dp             ctrl,
	input  logic              drain_en,
	input  logic [`RES_W-1:0] prod,
	input  logic [`RES_W-1:0] res_in,
	output logic [`RES_W-1:0] res_out
);

	logic [`RES_W-1:0] acc;

	// Draining and accumulating never overlap, so the order here only
	// matters when the rule below is broken.
	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= '0;
		end else if (drain_en) begin
			acc <= res_in; // Take the left neighbour's sum.
		end else if (ctrl.acc_en) begin
			acc <= acc + prod; // Wraps modulo 2^32.
		end
	end

	assign res_out = acc;

	// The drain comes from the top while acc_en comes from this PE's
	// sequencer, so a drain in the middle of a sequence would lose a product.
	a_no_drain_during_acc: assert property (
		@(posedge clk) disable iff (rst)
		!(drain_en && ctrl.acc_en)
	) else $error("drain_en high while accumulating");

endmodule

/* hdl/precision_ctrl.sv */
`timescale 1ns/100ps
`include "pe_defs.svh"

module precision_ctrl (
	input  logic   clk,
	input  logic   rst,
	input  logic   config_en,
	input  logic   config_in,
	output logic   config_out,
	input  logic   step,
	pe_ctrl_if.ctrl ctrl
);

	logic [`CFG_W-1:0] cfg_sr;
	pe_pkg::pe_cfg_t   cfg;
	logic              running;
	logic [1:0]        idx;   // Partial product being issued.
	logic              last;

	// Config chain, one bit per enabled cycle, MSB leaves first.
	always_ff @(posedge clk) begin
		if (rst) begin
			cfg_sr <= '0;
		end else if (config_en) begin
			cfg_sr <= {cfg_sr[`CFG_W-2:0], config_in};
		end
	end

	assign cfg        = pe_pkg::pe_cfg_t'(cfg_sr);
	assign config_out = cfg_sr[`CFG_W-1];

	assign last = ({1'b0, idx} == pe_pkg::pp_cycles(cfg.mode) - 3'd1);

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			idx     <= '0;
		end else if (step) begin
			running <= 1'b1;
			idx     <= '0;
		end else if (running) begin
			running <= !last;
			idx     <= idx + 2'd1;
		end
	end

	// idx[0] walks the activation half, idx[1] the weight half.
	// Only an upper half, or a whole 8-bit operand, carries the sign.
	always_comb begin
		ctrl.acc_en = running;
		case (cfg.mode)
			pe_pkg::P16X16: begin
				ctrl.a_sel  = !idx[0];
				ctrl.a_s    = idx[0] & cfg.a_signed;
				ctrl.b_addr = {1'b0, idx[1]};
				ctrl.b_s    = idx[1] & cfg.b_signed;
				ctrl.shift  = {1'b0, idx[0]} + {1'b0, idx[1]};
			end
			pe_pkg::P8X16: begin
				ctrl.a_sel  = 1'b0;
				ctrl.a_s    = cfg.a_signed;
				ctrl.b_addr = {1'b0, idx[0]};
				ctrl.b_s    = idx[0] & cfg.b_signed;
				ctrl.shift  = {1'b0, idx[0]};
			end
			default: begin
				ctrl.a_sel  = 1'b0;
				ctrl.a_s    = cfg.a_signed;
				ctrl.b_addr = '0;
				ctrl.b_s    = cfg.b_signed;
				ctrl.shift  = 2'd0;
			end
		endcase
	end

	// The feeder spaces its steps by the sequence length of column 0.
	a_step_idle: assert property (
		@(posedge clk) disable iff (rst) step |-> !running
	) else $error("step arrived while a sequence was running");

	a_cfg_idle: assert property (
		@(posedge clk) disable iff (rst) config_en |-> !running
	) else $error("config shifted during a sequence");

endmodule

/* hdl/pe.sv */
`timescale 1ns/100ps
`include "pe_defs.svh"

module pe (
	input  logic              clk,
	input  logic              rst,
	input  logic [`A_W-1:0]   feed_a,
	input  logic              feed_en,
	input  logic              step_in,
	output logic [`A_W-1:0]   feed_a_out,
	output logic              feed_en_out,
	output logic              step_out,
	input  logic [`B_W-1:0]   b_in,
	input  logic              b_en,
	output logic [`B_W-1:0]   b_cascade,
	input  logic [`RES_W-1:0] res_in,
	input  logic              drain_en,
	output logic [`RES_W-1:0] res_out,
	input  logic              config_en,
	input  logic              config_in,
	output logic              config_out
);

	pe_ctrl_if ctrl_bus ();

	logic [`A_W-1:0]   a_mul;
	logic [`B_W-1:0]   b_mul;
	logic [`RES_W-1:0] prod;

	// The byte itself is already registered inside the buffer.
	always_ff @(posedge clk) begin
		if (rst) begin
			feed_en_out <= 1'b0;
			step_out    <= 1'b0;
		end else begin
			feed_en_out <= feed_en;
			step_out    <= step_in;
		end
	end

	stream_flex i_flex (
		.clk   (clk),
		.rst   (rst),
		.a_in  (feed_a),
		.a_en  (feed_en),
		.ctrl  (ctrl_bus.dp),
		.a_fwd (feed_a_out),
		.a_mul (a_mul)
	);

	stream_mem i_mem (
		.clk       (clk),
		.rst       (rst),
		.b_in      (b_in),
		.b_en      (b_en),
		.ctrl      (ctrl_bus.dp),
		.b_mul     (b_mul),
		.b_cascade (b_cascade)
	);

	mult_shift i_mult (
		.a    (a_mul),
		.b    (b_mul),
		.ctrl (ctrl_bus.dp),
		.prod (prod)
	);

	accumulator i_acc (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrl_bus.dp),
		.drain_en (drain_en),
		.prod     (prod),
		.res_in   (res_in),
		.res_out  (res_out)
	);

	precision_ctrl i_prec (
		.clk        (clk),
		.rst        (rst),
		.config_en  (config_en),
		.config_in  (config_in),
		.config_out (config_out),
		.step       (step_in),
		.ctrl       (ctrl_bus.ctrl)
	);

endmodule

/* hdl/a_feeder.sv */
`timescale 1ns/100ps
`include "pe_defs.svh"

module a_feeder (
	input  logic                a_req,
	input  logic                clk,
	input  logic                rst,
	input  logic [2*`A_W-1:0]   a_data,
	output logic                a_ack,
	output logic                busy,
	input  pe_pkg::prec_mode_t  mode,
	output logic [`A_W-1:0]     feed_a,
	output logic                feed_en,
	output logic                step
);

	// Last column finishes its longest sequence this many cycles after the step.
	localparam int DRAIN_CYC = `PE_COLS + 3;
	localparam int DCNT_W    = $clog2(DRAIN_CYC + 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_BYTE_LO,
		S_BYTE_HI,
		S_STEP,
		S_WAIT,
		S_ACK
	} state_t;

	state_t            state;
	logic [2*`A_W-1:0] data;
	logic [2:0]        wcnt;
	logic [DCNT_W-1:0] dcnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			wcnt  <= '0;
		end else begin
			case (state)
				S_IDLE:    if (a_req) state <= S_BYTE_LO;
				S_BYTE_LO: state <= (mode == pe_pkg::P16X16) ? S_BYTE_HI : S_STEP;
				S_BYTE_HI: state <= S_STEP;
				S_STEP: begin
					state <= S_WAIT;
					wcnt  <= pe_pkg::pp_cycles(mode) - 3'd1;
				end
				S_WAIT: begin
					if (wcnt == '0) state <= S_ACK;
					else            wcnt  <= wcnt - 3'd1;
				end
				S_ACK:     if (!a_req) state <= S_IDLE; // Four-phase return to zero.
				default:   state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && a_req) data <= a_data;
	end

	// Keeps busy up while the step ripples to the last column.
	always_ff @(posedge clk) begin
		if (rst)                  dcnt <= '0;
		else if (state == S_STEP) dcnt <= DRAIN_CYC[DCNT_W-1:0];
		else if (dcnt != '0)      dcnt <= dcnt - 1'b1;
	end

	assign feed_en = (state == S_BYTE_LO) || (state == S_BYTE_HI);
	assign feed_a  = (state == S_BYTE_HI) ? data[2*`A_W-1:`A_W] : data[`A_W-1:0];
	assign step    = (state == S_STEP);
	assign a_ack   = (state == S_ACK);
	assign busy    = (state != S_IDLE && state != S_ACK) || (dcnt != '0);

	a_req_held: assert property (
		@(posedge clk) disable iff (rst) $fell(a_req) |-> a_ack
	) else $error("a_req dropped before a_ack");

endmodule

/* hdl/pe_array.sv */
`timescale 1ns/100ps
`include "pe_defs.svh"

module pe_array (
	input  logic              clk,
	input  logic              rst,
	input  logic              config_en,
	input  logic              config_in,
	output logic              config_out,
	input  logic              b_en,
	input  logic [`B_W-1:0]   b_in,
	input  logic              a_req,
	input  logic [2*`A_W-1:0] a_data,
	output logic              a_ack,
	output logic              busy,
	input  logic              drain_en,
	output logic [`RES_W-1:0] res_out
);

	// Element k feeds column k, element k+1 is column k's output.
	logic [`A_W-1:0]   feed_a_c  [0:`PE_COLS];
	logic              feed_en_c [0:`PE_COLS];
	logic              step_c    [0:`PE_COLS];
	logic [`B_W-1:0]   b_c       [0:`PE_COLS];
	logic [`RES_W-1:0] res_c     [0:`PE_COLS];
	logic              cfg_c     [0:`PE_COLS];

	logic [`CFG_W-1:0] col0_cfg_sr;
	pe_pkg::pe_cfg_t   col0_cfg;

	// Mirrors column 0's config word; it sees the same chain input.
	always_ff @(posedge clk) begin
		if (rst)            col0_cfg_sr <= '0;
		else if (config_en) col0_cfg_sr <= {col0_cfg_sr[`CFG_W-2:0], config_in};
	end

	assign col0_cfg = pe_pkg::pe_cfg_t'(col0_cfg_sr);

	a_feeder i_feeder (
		.clk     (clk),
		.rst     (rst),
		.a_req   (a_req),
		.a_data  (a_data),
		.a_ack   (a_ack),
		.busy    (busy),
		.mode    (col0_cfg.mode),
		.feed_a  (feed_a_c[0]),
		.feed_en (feed_en_c[0]),
		.step    (step_c[0])
	);

	assign b_c[0]   = b_in;
	assign res_c[0] = '0;   // Zero enters column 0 while draining.
	assign cfg_c[0] = config_in;

	for (genvar k = 0; k < `PE_COLS; k++) begin : g_col
		pe i_pe (
			.clk         (clk),
			.rst         (rst),
			.feed_a      (feed_a_c[k]),
			.feed_en     (feed_en_c[k]),
			.step_in     (step_c[k]),
			.feed_a_out  (feed_a_c[k+1]),
			.feed_en_out (feed_en_c[k+1]),
			.step_out    (step_c[k+1]),
			.b_in        (b_c[k]),
			.b_en        (b_en),
			.b_cascade   (b_c[k+1]),
			.res_in      (res_c[k]),
			.drain_en    (drain_en),
			.res_out     (res_c[k+1]),
			.config_en   (config_en),
			.config_in   (cfg_c[k]),
			.config_out  (cfg_c[k+1])
		);
	end

	assign res_out    = res_c[`PE_COLS];
	assign config_out = cfg_c[`PE_COLS];

	a_drain_idle: assert property (
		@(posedge clk) disable iff (rst) drain_en |-> !busy
	) else $error("drain_en high while busy");

endmodule

/* testbench/tb_pe_array.sv */
`timescale 1ns/100ps
`include "pe_defs.svh"

module tb_pe_array;

	localparam int CHAIN = `CFG_W * `PE_COLS; // Config bits held by the whole row.
	localparam int N_W   = `B_D * `PE_COLS;   // Weight words held by the whole row.
	localparam int TMO   = 200;               // Cycles allowed for any single wait.

	logic                clk = 1'b0;
	logic                rst;
	logic                config_en;
	logic                config_in;
	logic                config_out;
	logic                b_en;
	logic [`B_W-1:0]     b_in;
	logic                a_req;
	logic [2*`A_W-1:0]   a_data;
	logic                a_ack;
	logic                busy;
	logic                drain_en;
	logic [`RES_W-1:0]   res_out;

	logic [15:0]         lfsr = 16'd67;
	logic [`B_W-1:0]     w [0:`PE_COLS-1][0:`B_D-1]; // Weights as they sit in each column.
	logic [`RES_W-1:0]   exp_sum [0:`PE_COLS-1];
	pe_pkg::prec_mode_t  cur_mode;
	logic                cur_a_s;
	logic                cur_b_s;
	int                  errors = 0;
	int                  tests = 0;
	int                  ack_rises = 0;
	logic                ack_q = 1'b0;

	pe_array i_dut (
		.clk        (clk),
		.rst        (rst),
		.config_en  (config_en),
		.config_in  (config_in),
		.config_out (config_out),
		.b_en       (b_en),
		.b_in       (b_in),
		.a_req      (a_req),
		.a_data     (a_data),
		.a_ack      (a_ack),
		.busy       (busy),
		.drain_en   (drain_en),
		.res_out    (res_out)
	);

	always #2 clk = ~clk;

	// Counts rising edges of a_ack.
	always @(posedge clk) begin
		ack_q <= a_ack;
		if (a_ack && !ack_q) ack_rises <= ack_rises + 1;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) n = n ^ 16'hB400; // Galois feedback taps.
		return n;
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Whole product of one activation and a column's weight, modulo 2^32.
	function automatic logic [`RES_W-1:0] ref_product(input logic [15:0] a, input logic [15:0] wt);
		longint av;
		longint wv;
		longint p;
		av = cur_a_s ? longint'($signed(a[7:0])) : longint'(a[7:0]);
		wv = cur_b_s ? longint'($signed(wt[7:0])) : longint'(wt[7:0]);
		if (cur_mode == pe_pkg::P16X16) av = cur_a_s ? longint'($signed(a)) : longint'(a);
		if (cur_mode != pe_pkg::P8X8) wv = cur_b_s ? longint'($signed(wt)) : longint'(wt);
		p = av * wv;
		return p[`RES_W-1:0];
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		errors++;
		$display("ERROR at %0d ns: %s expected %h, got %h", $time, name, want, got);
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timeout at %0d ns: waited %0d cycles for %s", $time, TMO, what);
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, errors - err_before);
	endtask

	// The same word goes to every column, MSB first.
	task automatic configure(input pe_pkg::prec_mode_t mode, input logic a_s, input logic b_s);
		pe_pkg::pe_cfg_t word;
		word = '{mode: mode, a_signed: a_s, b_signed: b_s};
		cur_mode = mode;
		cur_a_s  = a_s;
		cur_b_s  = b_s;
		for (int c = 0; c < `PE_COLS; c++) begin
			for (int i = `CFG_W-1; i >= 0; i--) begin
				config_en = 1'b1;
				config_in = word[i];
				next_cycle();
			end
		end
		config_en = 1'b0;
	endtask

	task automatic random_weights();
		logic [15:0] v;
		for (int c = 0; c < `PE_COLS; c++) begin
			for (int a = 0; a < `B_D; a++) begin
				take_bits(8, v);
				w[c][a] = v[7:0];
			end
		end
	endtask

	// Word j lands in column PE_COLS-1-j/B_D at address B_D-1-j%B_D.
	task automatic load_weights();
		for (int j = 0; j < N_W; j++) begin
			b_en = 1'b1;
			b_in = w[`PE_COLS-1-j/`B_D][`B_D-1-j%`B_D];
			next_cycle();
		end
		b_en = 1'b0;
	endtask

	task automatic send_act(input logic [15:0] data);
		int n;
		a_data = data;
		a_req  = 1'b1;
		n = 0;
		while (!a_ack && n < TMO) begin
			next_cycle();
			n++;
		end
		if (!a_ack) report_timeout("rise of a_ack");
		a_req = 1'b0;
		n = 0;
		while (a_ack && n < TMO) begin
			next_cycle();
			n++;
		end
		if (a_ack) report_timeout("fall of a_ack");
		for (int c = 0; c < `PE_COLS; c++) begin
			exp_sum[c] += ref_product(data, {w[c][1], w[c][0]});
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < TMO) begin
			next_cycle();
			n++;
		end
		if (busy) report_timeout("fall of busy");
	endtask

	// The last column comes out first.
	task automatic drain_and_check();
		for (int c = `PE_COLS-1; c >= 0; c--) begin
			if (res_out !== exp_sum[c]) begin
				report_mismatch($sformatf("res_out (column %0d)", c), res_out, exp_sum[c]);
			end
			drain_en = 1'b1;
			next_cycle();
			exp_sum[c] = '0;
		end
		drain_en = 1'b0;
	endtask

	task automatic test_config_chain();
		logic [15:0] v;
		logic        bits [0:CHAIN+7];
		int          e0;
		e0 = errors;
		for (int i = 0; i < CHAIN + 8; i++) begin
			take_bits(1, v);
			bits[i]   = v[0];
			config_en = 1'b1;
			config_in = v[0];
			next_cycle();
			if (i < CHAIN - 1) begin
				if (config_out !== 1'b0) report_mismatch("config_out", config_out, 0);
			end else if (config_out !== bits[i-CHAIN+1]) begin
				report_mismatch("config_out", config_out, bits[i-CHAIN+1]);
			end
		end
		config_en = 1'b0;
		finish_test("config chain passthrough", e0);
	endtask

	task automatic test_mac(input string name, input pe_pkg::prec_mode_t mode, input logic a_s,
			input logic b_s, input logic extremes);
		logic [15:0] v;
		int          e0;
		e0 = errors;
		configure(mode, a_s, b_s);
		random_weights();
		if (extremes) begin
			w[0][1] = 8'h80; // Column 0 weight is -32768.
			w[0][0] = 8'h00;
			w[1][1] = 8'h7f;
			w[1][0] = 8'hff;
		end
		load_weights();
		if (extremes) begin
			send_act(16'h8000);
			send_act(16'h7fff);
			send_act(16'hffff);
		end
		for (int i = 0; i < 6; i++) begin
			take_bits(16, v);
			send_act(v);
		end
		wait_idle();
		drain_and_check();
		finish_test(name, e0);
	endtask

	task automatic test_drain_clears();
		int e0;
		e0 = errors;
		drain_and_check(); // Every expected sum is zero after the last drain.
		finish_test("drain clears", e0);
	endtask

	task automatic test_handshake();
		logic [15:0] v;
		int          e0;
		int          rises0;
		int          n;
		e0 = errors;
		configure(pe_pkg::P8X8, 1'b0, 1'b0);
		for (int i = 0; i < 6; i++) begin
			next_cycle();
			if (a_ack !== 1'b0) report_mismatch("a_ack", a_ack, 0);
		end
		rises0 = ack_rises;
		take_bits(16, v);
		a_data = v;
		a_req  = 1'b1;
		n = 0;
		while (!a_ack && n < TMO) begin
			next_cycle();
			n++;
		end
		if (!a_ack) report_timeout("rise of a_ack");
		// The request stays up through the whole busy period.
		n = 0;
		while (busy && n < TMO) begin
			next_cycle();
			n++;
			if (a_ack !== 1'b1) report_mismatch("a_ack", a_ack, 1);
		end
		// Busy ends PE_COLS+4 cycles after the step, and an 8x8 a_ack comes two after it.
		if (busy) report_timeout("fall of busy");
		else if (n != `PE_COLS + 2) report_mismatch("busy cycles after a_ack", n, `PE_COLS + 2);
		a_req = 1'b0;
		n = 0;
		while (a_ack && n < TMO) begin
			next_cycle();
			n++;
		end
		if (a_ack) report_timeout("fall of a_ack");
		for (int i = 0; i < 8; i++) begin
			next_cycle();
			if (a_ack !== 1'b0) report_mismatch("a_ack", a_ack, 0);
		end
		if (ack_rises - rises0 != 1) report_mismatch("a_ack rise count", ack_rises - rises0, 1);
		for (int c = 0; c < `PE_COLS; c++) begin
			exp_sum[c] += ref_product(v, {w[c][1], w[c][0]});
		end
		drain_and_check(); // One accepted request means one product per column.
		finish_test("handshake rules", e0);
	endtask

	initial begin
		rst       = 1'b1;
		config_en = 1'b0;
		config_in = 1'b0;
		b_en      = 1'b0;
		b_in      = '0;
		a_req     = 1'b0;
		a_data    = '0;
		drain_en  = 1'b0;
		cur_mode  = pe_pkg::P8X8;
		cur_a_s   = 1'b0;
		cur_b_s   = 1'b0;
		for (int c = 0; c < `PE_COLS; c++) begin
			exp_sum[c] = '0;
		end
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		test_config_chain();
		test_mac("unsigned 8x8", pe_pkg::P8X8, 1'b0, 1'b0, 1'b0);
		test_mac("signed 8x16", pe_pkg::P8X16, 1'b1, 1'b1, 1'b0);
		test_mac("signed 16x16", pe_pkg::P16X16, 1'b1, 1'b1, 1'b1);
		test_drain_clears();
		test_handshake();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+hdl
hdl/pe_pkg.sv
hdl/pe_ctrl_if.sv
hdl/stream_flex.sv
hdl/stream_mem.sv
hdl/mult_shift.sv
hdl/accumulator.sv
hdl/precision_ctrl.sv
hdl/pe.sv
hdl/a_feeder.sv
hdl/pe_array.sv
testbench/tb_pe_array.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_pe_array -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
